//--- logic/bflyPkg.sv
// bflyPkg: sizes, widths and payload types shared by the 8x8 butterfly network
`default_nettype none

package bflyPkg;

  // network geometry, one master per target
  localparam int unsigned NumPorts    = 8;
  localparam int unsigned AddrWidth   = 3;
  localparam int unsigned IdxWidth    = 3;
  localparam int unsigned NumStages   = 3;
  localparam int unsigned NumSwitches = 4;

  // data widths seen at the network edge
  localparam int unsigned ReqDataWidth  = 32;
  localparam int unsigned RespDataWidth = 32;

  // what a switchbox carries: remaining address, master index and write data
  localparam int unsigned ReqPayloadWidth  = AddrWidth + IdxWidth + ReqDataWidth;
  // response side carries the remaining index bits and read data
  localparam int unsigned RespPayloadWidth = IdxWidth + RespDataWidth;

  // priority generator, x^16 + x^14 + x^13 + x^11 + 1
  localparam int unsigned          LfsrWidth = 16;
  localparam logic [LfsrWidth-1:0] LfsrTaps  = 16'hB400;
  localparam logic [LfsrWidth-1:0] LfsrSeed  = 16'hACE1;

  // target address
  typedef logic [AddrWidth-1:0] addrT;

  // master index
  typedef logic [IdxWidth-1:0] idxT;

  typedef logic [ReqDataWidth-1:0]  wdataT;
  typedef logic [RespDataWidth-1:0] rdataT;

  // bundled payloads as they pass through a switchbox
  typedef logic [ReqPayloadWidth-1:0]  reqPayloadT;
  typedef logic [RespPayloadWidth-1:0] respPayloadT;

endpackage

`default_nettype wire

//--- logic/bflySwitch.sv
// bflySwitch: 2x2 switchbox, arbitrates requests forward and routes responses back
`timescale 1ns/1ns
`default_nettype none

module bflySwitch (
  // request side, inputs from the master direction
  input  logic [1:0]                       req_i,
  input  logic [1:0]                       addr_i,
  input  bflyPkg::reqPayloadT [1:0]        data_i,
  output logic [1:0]                       gnt_o,
  // request side, outputs toward the targets
  output logic [1:0]                       req_o,
  output bflyPkg::reqPayloadT [1:0]        data_o,
  input  logic [1:0]                       gnt_i,
  // response side, inputs from the target direction
  input  logic [1:0]                       vld_i,
  input  logic [1:0]                       idxBit_i,
  input  bflyPkg::respPayloadT [1:0]       rdata_i,
  output logic [1:0]                       rdy_o,
  // response side, outputs toward the masters
  output logic [1:0]                       vld_o,
  output bflyPkg::respPayloadT [1:0]       rdata_o,
  input  logic [1:0]                       rdy_i,
  // tie-break bit, names the input that wins a conflict
  input  logic                             prio_i
);

  // [destination][source] wish matrices
  logic [1:0][1:0] reqWant;
  logic [1:0][1:0] rspWant;

  // source that owns each destination
  logic [1:0] reqSel;
  logic [1:0] rspSel;

  // one contender takes the port, two contenders defer to the priority bit
  function automatic logic pickSrc(input logic [1:0] want, input logic prio);
    logic src;
    if (want == 2'b11) begin
      src = prio;
    end else begin
      src = want[1];
    end
    return src;
  endfunction

  // requests steer by their address bit
  always_comb begin
    for (int o = 0; o < 2; o++) begin
      for (int p = 0; p < 2; p++) begin
        reqWant[o][p] = req_i[p] && (addr_i[p] == 1'(o));
      end
      reqSel[o] = pickSrc(reqWant[o], prio_i);
      req_o[o]  = |reqWant[o];
      data_o[o] = data_i[reqSel[o]];
    end
    // only the owner of the requested output hears the grant
    for (int p = 0; p < 2; p++) begin
      gnt_o[p] = req_i[p] && gnt_i[addr_i[p]] && (reqSel[addr_i[p]] == 1'(p));
    end
  end

  // responses steer by their index bit, mirror of the request side
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      for (int o = 0; o < 2; o++) begin
        rspWant[p][o] = vld_i[o] && (idxBit_i[o] == 1'(p));
      end
      rspSel[p]  = pickSrc(rspWant[p], prio_i);
      vld_o[p]   = |rspWant[p];
      rdata_o[p] = rdata_i[rspSel[p]];
    end
    for (int o = 0; o < 2; o++) begin
      rdy_o[o] = vld_i[o] && rdy_i[idxBit_i[o]] && (rspSel[idxBit_i[o]] == 1'(o));
    end
  end

  // grants and readies only go back to live contenders, one per destination
  always_comb begin
    assert final ((gnt_o & ~req_i) == 2'b00)
      else $error("switchbox grant without a request");
    assert final (!(gnt_o[0] && gnt_o[1] && (addr_i[0] == addr_i[1])))
      else $error("switchbox request output with two winners");
    assert final ((rdy_o & ~vld_i) == 2'b00)
      else $error("switchbox ready without a response");
    assert final (!(rdy_o[0] && rdy_o[1] && (idxBit_i[0] == idxBit_i[1])))
      else $error("switchbox response output with two winners");
  end

endmodule

`default_nettype wire

//--- logic/bflyStage.sv
// bflyStage: one butterfly column of four switchboxes, consumes one address and index bit
`timescale 1ns/1ns
`default_nettype none

module bflyStage (
  // request side toward the masters
  input  logic [bflyPkg::NumPorts-1:0]                   req_i,
  input  bflyPkg::addrT [bflyPkg::NumPorts-1:0]          addr_i,
  input  bflyPkg::idxT [bflyPkg::NumPorts-1:0]           idx_i,
  input  bflyPkg::wdataT [bflyPkg::NumPorts-1:0]         wdata_i,
  output logic [bflyPkg::NumPorts-1:0]                   gnt_o,
  // request side toward the targets
  output logic [bflyPkg::NumPorts-1:0]                   req_o,
  output bflyPkg::addrT [bflyPkg::NumPorts-1:0]          addr_o,
  output bflyPkg::idxT [bflyPkg::NumPorts-1:0]           idx_o,
  output bflyPkg::wdataT [bflyPkg::NumPorts-1:0]         wdata_o,
  input  logic [bflyPkg::NumPorts-1:0]                   gnt_i,
  // response side toward the targets
  input  logic [bflyPkg::NumPorts-1:0]                   vld_i,
  input  bflyPkg::idxT [bflyPkg::NumPorts-1:0]           respIdx_i,
  input  bflyPkg::rdataT [bflyPkg::NumPorts-1:0]         rdata_i,
  output logic [bflyPkg::NumPorts-1:0]                   rdy_o,
  // response side toward the masters
  output logic [bflyPkg::NumPorts-1:0]                   vld_o,
  output bflyPkg::idxT [bflyPkg::NumPorts-1:0]           respIdx_o,
  output bflyPkg::rdataT [bflyPkg::NumPorts-1:0]         rdata_o,
  input  logic [bflyPkg::NumPorts-1:0]                   rdy_i,
  input  logic                                           prio_i
);

  logic [bflyPkg::NumPorts-1:0]                addrBit;
  logic [bflyPkg::NumPorts-1:0]                idxBit;
  bflyPkg::reqPayloadT [bflyPkg::NumPorts-1:0]  reqDataIn;
  bflyPkg::reqPayloadT [bflyPkg::NumPorts-1:0]  reqDataOut;
  bflyPkg::respPayloadT [bflyPkg::NumPorts-1:0] rspDataIn;
  bflyPkg::respPayloadT [bflyPkg::NumPorts-1:0] rspDataOut;

  for (genvar p = 0; p < bflyPkg::NumPorts; p++) begin : genPort
    // this stage steers on the top bit, the next one finds its bit at the top again
    assign addrBit[p]   = addr_i[p][bflyPkg::AddrWidth-1];
    assign reqDataIn[p] = {addr_i[p][bflyPkg::AddrWidth-2:0], 1'b0, idx_i[p], wdata_i[p]};
    assign {addr_o[p], idx_o[p], wdata_o[p]} = reqDataOut[p];

    assign idxBit[p]    = respIdx_i[p][bflyPkg::IdxWidth-1];
    assign rspDataIn[p] = {respIdx_i[p][bflyPkg::IdxWidth-2:0], 1'b0, rdata_i[p]};
    assign {respIdx_o[p], rdata_o[p]} = rspDataOut[p];
  end

  // switchbox k owns ports 2k and 2k+1 on both sides
  for (genvar k = 0; k < bflyPkg::NumSwitches; k++) begin : genSwitch
    bflySwitch switch_i (
      .req_i    (req_i[2*k +: 2]),
      .addr_i   (addrBit[2*k +: 2]),
      .data_i   (reqDataIn[2*k +: 2]),
      .gnt_o    (gnt_o[2*k +: 2]),
      .req_o    (req_o[2*k +: 2]),
      .data_o   (reqDataOut[2*k +: 2]),
      .gnt_i    (gnt_i[2*k +: 2]),
      .vld_i    (vld_i[2*k +: 2]),
      .idxBit_i (idxBit[2*k +: 2]),
      .rdata_i  (rspDataIn[2*k +: 2]),
      .rdy_o    (rdy_o[2*k +: 2]),
      .vld_o    (vld_o[2*k +: 2]),
      .rdata_o  (rspDataOut[2*k +: 2]),
      .rdy_i    (rdy_i[2*k +: 2]),
      .prio_i   (prio_i)
    );
  end

endmodule

`default_nettype wire

//--- logic/bflyPrioLfsr.sv
// bflyPrioLfsr: Galois shift register that supplies the switchbox tie-break bits
`timescale 1ns/1ns
`default_nettype none

module bflyPrioLfsr (
  input  logic          clk_i,
  input  logic          rstN_i,
  // step once per cycle with an accepted request
  input  logic          en_i,
  output bflyPkg::addrT prio_o
);

  logic [bflyPkg::LfsrWidth-1:0] lfsrQ;
  logic [bflyPkg::LfsrWidth-1:0] lfsrD;

  // right shifting Galois form, feedback folds in wherever a tap is set
  always_comb begin
    lfsrD = lfsrQ >> 1;
    if (lfsrQ[0]) begin
      lfsrD = lfsrD ^ bflyPkg::LfsrTaps;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rstN_i) begin
      lfsrQ <= bflyPkg::LfsrSeed;
    end else if (en_i) begin
      lfsrQ <= lfsrD;
    end
  end

  // one bit per stage
  assign prio_o = lfsrQ[bflyPkg::AddrWidth-1:0];

  // a maximal polynomial never falls into the all-zero lockup state
  lfsrNonZero: assert property (
    @(posedge clk_i) disable iff (!rstN_i) lfsrQ != '0
  ) else $error("priority register reached the all-zero state");

endmodule

`default_nettype wire

//--- logic/bflyNet.sv
// bflyNet: 8x8 radix-2 butterfly network between masters and target banks
`timescale 1ns/1ns
`default_nettype none

module bflyNet (
  input  logic                                   clk_i,
  input  logic                                   rstN_i,
  // master side
  input  logic [bflyPkg::NumPorts-1:0]           req_i,
  output logic [bflyPkg::NumPorts-1:0]           gnt_o,
  input  bflyPkg::addrT [bflyPkg::NumPorts-1:0]  addr_i,
  input  bflyPkg::wdataT [bflyPkg::NumPorts-1:0] wdata_i,
  output logic [bflyPkg::NumPorts-1:0]           vld_o,
  input  logic [bflyPkg::NumPorts-1:0]           rdy_i,
  output bflyPkg::rdataT [bflyPkg::NumPorts-1:0] rdata_o,
  // target side
  output logic [bflyPkg::NumPorts-1:0]           req_o,
  input  logic [bflyPkg::NumPorts-1:0]           gnt_i,
  output bflyPkg::idxT [bflyPkg::NumPorts-1:0]   idx_o,
  output bflyPkg::wdataT [bflyPkg::NumPorts-1:0] wdata_o,
  input  logic [bflyPkg::NumPorts-1:0]           vld_i,
  output logic [bflyPkg::NumPorts-1:0]           rdy_o,
  input  bflyPkg::idxT [bflyPkg::NumPorts-1:0]   idx_i,
  input  bflyPkg::rdataT [bflyPkg::NumPorts-1:0] rdata_i
);

  // per stage port arrays, In is the master facing side and Out the target facing side
  logic [bflyPkg::NumPorts-1:0]           stgReqIn     [bflyPkg::NumStages];
  logic [bflyPkg::NumPorts-1:0]           stgReqOut    [bflyPkg::NumStages];
  bflyPkg::addrT [bflyPkg::NumPorts-1:0]  stgAddrIn    [bflyPkg::NumStages];
  bflyPkg::addrT [bflyPkg::NumPorts-1:0]  stgAddrOut   [bflyPkg::NumStages];
  bflyPkg::idxT [bflyPkg::NumPorts-1:0]   stgIdxIn     [bflyPkg::NumStages];
  bflyPkg::idxT [bflyPkg::NumPorts-1:0]   stgIdxOut    [bflyPkg::NumStages];
  bflyPkg::wdataT [bflyPkg::NumPorts-1:0] stgWdataIn   [bflyPkg::NumStages];
  bflyPkg::wdataT [bflyPkg::NumPorts-1:0] stgWdataOut  [bflyPkg::NumStages];
  logic [bflyPkg::NumPorts-1:0]           stgGntIn     [bflyPkg::NumStages];
  logic [bflyPkg::NumPorts-1:0]           stgGntOut    [bflyPkg::NumStages];
  logic [bflyPkg::NumPorts-1:0]           stgVldIn     [bflyPkg::NumStages];
  logic [bflyPkg::NumPorts-1:0]           stgVldOut    [bflyPkg::NumStages];
  bflyPkg::idxT [bflyPkg::NumPorts-1:0]   stgRespIdxIn [bflyPkg::NumStages];
  bflyPkg::idxT [bflyPkg::NumPorts-1:0]   stgRespIdxOut[bflyPkg::NumStages];
  bflyPkg::rdataT [bflyPkg::NumPorts-1:0] stgRdataIn   [bflyPkg::NumStages];
  bflyPkg::rdataT [bflyPkg::NumPorts-1:0] stgRdataOut  [bflyPkg::NumStages];
  logic [bflyPkg::NumPorts-1:0]           stgRdyIn     [bflyPkg::NumStages];
  logic [bflyPkg::NumPorts-1:0]           stgRdyOut    [bflyPkg::NumStages];

  bflyPkg::addrT prio;
  logic          prioEn;

  // Link after stage l rotates the low NumStages-l position bits right by one.
  // Requests then land on their address, and responses steered MSB first
  // retrace the same path back to the master that sent the request.
  function automatic int unsigned nextPos(input int unsigned stage, input int unsigned pos);
    int unsigned span;
    int unsigned low;
    span = 1 << (bflyPkg::NumStages - stage);
    low  = pos % span;
    return pos - low + (low >> 1) + (low % 2) * (span >> 1);
  endfunction

  // master side enters stage 0, each request tagged with its own index
  assign stgReqIn[0]   = req_i;
  assign stgAddrIn[0]  = addr_i;
  assign stgWdataIn[0] = wdata_i;
  assign stgRdyIn[0]   = rdy_i;
  assign gnt_o         = stgGntOut[0];
  assign vld_o         = stgVldOut[0];
  assign rdata_o       = stgRdataOut[0];

  for (genvar m = 0; m < bflyPkg::NumPorts; m++) begin : genInject
    assign stgIdxIn[0][m] = bflyPkg::idxT'(m);
  end

  // target side leaves the last stage
  assign req_o   = stgReqOut[bflyPkg::NumStages-1];
  assign idx_o   = stgIdxOut[bflyPkg::NumStages-1];
  assign wdata_o = stgWdataOut[bflyPkg::NumStages-1];
  assign rdy_o   = stgRdyOut[bflyPkg::NumStages-1];
  assign stgGntIn[bflyPkg::NumStages-1]     = gnt_i;
  assign stgVldIn[bflyPkg::NumStages-1]     = vld_i;
  assign stgRespIdxIn[bflyPkg::NumStages-1] = idx_i;
  assign stgRdataIn[bflyPkg::NumStages-1]   = rdata_i;

  for (genvar l = 0; l < bflyPkg::NumStages - 1; l++) begin : genLink
    for (genvar p = 0; p < bflyPkg::NumPorts; p++) begin : genPort
      // forward
      assign stgReqIn[l+1][nextPos(l, p)]   = stgReqOut[l][p];
      assign stgAddrIn[l+1][nextPos(l, p)]  = stgAddrOut[l][p];
      assign stgIdxIn[l+1][nextPos(l, p)]   = stgIdxOut[l][p];
      assign stgWdataIn[l+1][nextPos(l, p)] = stgWdataOut[l][p];
      assign stgRdyIn[l+1][nextPos(l, p)]   = stgRdyOut[l][p];
      // backward
      assign stgGntIn[l][p]     = stgGntOut[l+1][nextPos(l, p)];
      assign stgVldIn[l][p]     = stgVldOut[l+1][nextPos(l, p)];
      assign stgRespIdxIn[l][p] = stgRespIdxOut[l+1][nextPos(l, p)];
      assign stgRdataIn[l][p]   = stgRdataOut[l+1][nextPos(l, p)];
    end
  end

  for (genvar l = 0; l < bflyPkg::NumStages; l++) begin : genStage
    bflyStage stage_i (
      .req_i     (stgReqIn[l]),
      .addr_i    (stgAddrIn[l]),
      .idx_i     (stgIdxIn[l]),
      .wdata_i   (stgWdataIn[l]),
      .gnt_o     (stgGntOut[l]),
      .req_o     (stgReqOut[l]),
      .addr_o    (stgAddrOut[l]),
      .idx_o     (stgIdxOut[l]),
      .wdata_o   (stgWdataOut[l]),
      .gnt_i     (stgGntIn[l]),
      .vld_i     (stgVldIn[l]),
      .respIdx_i (stgRespIdxIn[l]),
      .rdata_i   (stgRdataIn[l]),
      .rdy_o     (stgRdyOut[l]),
      .vld_o     (stgVldOut[l]),
      .respIdx_o (stgRespIdxOut[l]),
      .rdata_o   (stgRdataOut[l]),
      .rdy_i     (stgRdyIn[l]),
      .prio_i    (prio[bflyPkg::AddrWidth-1-l])
    );
  end

  // priorities move on only when some target takes a request
  assign prioEn = |(req_o & gnt_i);

  bflyPrioLfsr lfsr_i (
    .clk_i  (clk_i),
    .rstN_i (rstN_i),
    .en_i   (prioEn),
    .prio_o (prio)
  );

  netGntHasReq: assert property (
    @(posedge clk_i) disable iff (!rstN_i) (gnt_o & ~req_i) == '0
  ) else $error("grant returned to a master without a request");

  // a winner's request reached its own target, tagged with its own index
  for (genvar m = 0; m < bflyPkg::NumPorts; m++) begin : genGntChk
    netGntPath: assert property (
      @(posedge clk_i) disable iff (!rstN_i)
      gnt_o[m] |-> req_o[addr_i[m]] && gnt_i[addr_i[m]]
                   && (idx_o[addr_i[m]] == bflyPkg::idxT'(m))
    ) else $error("grant to master %0d without a matching target request", m);
  end

endmodule

`default_nettype wire

//--- test/bflyNetTbTable.svh
// bflyNetTbTable: stimulus and expected-value table for the butterfly network testbench
`ifndef BFLY_NET_TB_TABLE_SVH
`define BFLY_NET_TB_TABLE_SVH

// plain entries have one requester and one responder, conflict entries two requesters
typedef enum logic {ChkPlain, ChkConflict} chkKindT;

typedef struct packed {
  chkKindT                      kind;
  logic [7:0]                   reps;
  logic [bflyPkg::NumPorts-1:0] reqMask;
  bflyPkg::addrT                reqAddr;
  logic [bflyPkg::NumPorts-1:0] gntMask;
  logic [bflyPkg::NumPorts-1:0] vldMask;
  bflyPkg::idxT                 respIdx;
  logic [bflyPkg::NumPorts-1:0] rdyMask;
  logic [bflyPkg::NumPorts-1:0] expReqO;
  logic [bflyPkg::NumPorts-1:0] expGntO;
  logic [bflyPkg::NumPorts-1:0] expVldO;
  logic [bflyPkg::NumPorts-1:0] expRdyO;
} stimEntryT;

localparam int NumEntries = 18;

// columns: kind, reps, req mask, addr, gnt_i, vld_i mask, idx_i, rdy_i,
// then expected req_o, gnt_o, vld_o, rdy_o
stimEntryT stimTable [NumEntries] = '{
  '{ChkPlain,    8'd4,  8'h00, 3'd0, 8'h00, 8'h00, 3'd0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
  '{ChkPlain,    8'd1,  8'h01, 3'd5, 8'h20, 8'h00, 3'd0, 8'h00, 8'h20, 8'h01, 8'h00, 8'h00},
  '{ChkPlain,    8'd1,  8'h08, 3'd3, 8'h08, 8'h00, 3'd0, 8'h00, 8'h08, 8'h08, 8'h00, 8'h00},
  '{ChkPlain,    8'd1,  8'h80, 3'd0, 8'h01, 8'h00, 3'd0, 8'h00, 8'h01, 8'h80, 8'h00, 8'h00},
  '{ChkPlain,    8'd1,  8'h40, 3'd1, 8'hff, 8'h00, 3'd0, 8'h00, 8'h02, 8'h40, 8'h00, 8'h00},
  // target 6 stalls master 2, then takes it
  '{ChkPlain,    8'd3,  8'h04, 3'd6, 8'h00, 8'h00, 3'd0, 8'h00, 8'h40, 8'h00, 8'h00, 8'h00},
  '{ChkPlain,    8'd1,  8'h04, 3'd6, 8'h40, 8'h00, 3'd0, 8'h00, 8'h40, 8'h04, 8'h00, 8'h00},
  '{ChkPlain,    8'd2,  8'h20, 3'd2, 8'hfb, 8'h00, 3'd0, 8'h00, 8'h04, 8'h00, 8'h00, 8'h00},
  '{ChkPlain,    8'd1,  8'h20, 3'd2, 8'h04, 8'h00, 3'd0, 8'h00, 8'h04, 8'h20, 8'h00, 8'h00},
  // responses
  '{ChkPlain,    8'd1,  8'h00, 3'd0, 8'h00, 8'h10, 3'd1, 8'h02, 8'h00, 8'h00, 8'h02, 8'h10},
  '{ChkPlain,    8'd3,  8'h00, 3'd0, 8'h00, 8'h01, 3'd7, 8'h00, 8'h00, 8'h00, 8'h80, 8'h00},
  '{ChkPlain,    8'd1,  8'h00, 3'd0, 8'h00, 8'h01, 3'd7, 8'h80, 8'h00, 8'h00, 8'h80, 8'h01},
  '{ChkPlain,    8'd1,  8'h00, 3'd0, 8'h00, 8'h40, 3'd6, 8'hff, 8'h00, 8'h00, 8'h40, 8'h40},
  '{ChkPlain,    8'd1,  8'h10, 3'd7, 8'h80, 8'h04, 3'd4, 8'h10, 8'h80, 8'h10, 8'h10, 8'h04},
  '{ChkPlain,    8'd1,  8'h00, 3'd0, 8'h00, 8'h08, 3'd5, 8'hff, 8'h00, 8'h00, 8'h20, 8'h08},
  // two masters on one target, pairs meet at different stages
  '{ChkConflict, 8'd32, 8'h11, 3'd5, 8'h20, 8'h00, 3'd0, 8'h00, 8'h20, 8'h00, 8'h00, 8'h00},
  '{ChkConflict, 8'd32, 8'h0c, 3'd0, 8'h01, 8'h00, 3'd0, 8'h00, 8'h01, 8'h00, 8'h00, 8'h00},
  '{ChkPlain,    8'd2,  8'h00, 3'd0, 8'h00, 8'h00, 3'd0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00}
};

`endif

//--- test/bflyNetTb.sv
// bflyNetTb: drives the butterfly network from a stimulus table and checks both paths
`timescale 1ns/1ns
`default_nettype none

module bflyNetTb;

  localparam int ClkPeriod     = 20;
  localparam int ResetCycles   = 4;
  localparam int DriveDelay    = 2;
  localparam int TimeoutMargin = 20;

  logic clk;
  logic rstN;

  // master side
  logic [bflyPkg::NumPorts-1:0]           mstReq;
  logic [bflyPkg::NumPorts-1:0]           mstGnt;
  bflyPkg::addrT [bflyPkg::NumPorts-1:0]  mstAddr;
  bflyPkg::wdataT [bflyPkg::NumPorts-1:0] mstWdata;
  logic [bflyPkg::NumPorts-1:0]           mstVld;
  logic [bflyPkg::NumPorts-1:0]           mstRdy;
  bflyPkg::rdataT [bflyPkg::NumPorts-1:0] mstRdata;
  // target side
  logic [bflyPkg::NumPorts-1:0]           tgtReq;
  logic [bflyPkg::NumPorts-1:0]           tgtGnt;
  bflyPkg::idxT [bflyPkg::NumPorts-1:0]   tgtIdx;
  bflyPkg::wdataT [bflyPkg::NumPorts-1:0] tgtWdata;
  logic [bflyPkg::NumPorts-1:0]           tgtVld;
  logic [bflyPkg::NumPorts-1:0]           tgtRdy;
  bflyPkg::idxT [bflyPkg::NumPorts-1:0]   tgtRespIdx;
  bflyPkg::rdataT [bflyPkg::NumPorts-1:0] tgtRdata;

  int     errCount = 0;
  int     checkCount = 0;
  int     cycleCount = 0;
  int     timeoutLimit = 0;
  integer seed;
  int     winCount [bflyPkg::NumPorts];

  // contenders seen in conflict entries, and transfers still waiting for acceptance
  logic [bflyPkg::NumPorts-1:0] conflictMask;
  logic [bflyPkg::NumPorts-1:0] reqPending;
  logic [bflyPkg::NumPorts-1:0] rspPending;

  `include "bflyNetTbTable.svh"

  bflyNet dut_i (
    .clk_i   (clk),
    .rstN_i  (rstN),
    .req_i   (mstReq),
    .gnt_o   (mstGnt),
    .addr_i  (mstAddr),
    .wdata_i (mstWdata),
    .vld_o   (mstVld),
    .rdy_i   (mstRdy),
    .rdata_o (mstRdata),
    .req_o   (tgtReq),
    .gnt_i   (tgtGnt),
    .idx_o   (tgtIdx),
    .wdata_o (tgtWdata),
    .vld_i   (tgtVld),
    .rdy_o   (tgtRdy),
    .idx_i   (tgtRespIdx),
    .rdata_i (tgtRdata)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (timeoutLimit > 0 && cycleCount > timeoutLimit) begin
      $display("timeout after %0d cycles, the table never finished", cycleCount);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    assert (got === exp) else begin
      errCount++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic checkTrue(input bit cond, input string what);
    checkCount++;
    assert (cond) else begin
      errCount++;
      $display("%s", what);
    end
  endtask

  // held transfers keep their data, fresh ones get new random data
  task automatic applyEntry(input stimEntryT e);
    for (int p = 0; p < bflyPkg::NumPorts; p++) begin
      mstReq[p]     = e.reqMask[p];
      mstAddr[p]    = e.reqAddr;
      tgtGnt[p]     = e.gntMask[p];
      tgtVld[p]     = e.vldMask[p];
      tgtRespIdx[p] = e.respIdx;
      if (!reqPending[p]) begin
        mstWdata[p] = $random(seed);
      end
      if (!rspPending[p]) begin
        tgtRdata[p] = $random(seed);
      end
    end
    mstRdy = e.rdyMask;
  endtask

  task automatic checkEntry(input stimEntryT e);
    int winner;
    winner = -1;
    checkValue("req_o", tgtReq, e.expReqO);
    checkValue("vld_o", mstVld, e.expVldO);
    checkValue("rdy_o", tgtRdy, e.expRdyO);
    if (e.kind == ChkPlain) begin
      checkValue("gnt_o", mstGnt, e.expGntO);
      for (int m = 0; m < bflyPkg::NumPorts; m++) begin
        if (e.reqMask[m]) begin
          checkValue($sformatf("idx_o[%0d]", e.reqAddr), tgtIdx[e.reqAddr], m);
          checkValue($sformatf("wdata_o[%0d]", e.reqAddr), tgtWdata[e.reqAddr], mstWdata[m]);
        end
      end
    end else begin
      checkTrue($countones(mstGnt) == 1 && (mstGnt & ~e.reqMask) == '0,
                "conflict did not grant exactly one of the two contending masters");
      for (int m = 0; m < bflyPkg::NumPorts; m++) begin
        if (mstGnt[m]) begin
          winner = m;
        end
      end
      if (winner >= 0) begin
        winCount[winner]++;
        checkValue($sformatf("idx_o[%0d]", e.reqAddr), tgtIdx[e.reqAddr], winner);
        checkValue($sformatf("wdata_o[%0d]", e.reqAddr), tgtWdata[e.reqAddr],
                   mstWdata[winner]);
      end
      conflictMask = conflictMask | e.reqMask;
    end
    // the response lands at the master its index names
    for (int t = 0; t < bflyPkg::NumPorts; t++) begin
      if (e.vldMask[t]) begin
        checkValue($sformatf("rdata_o[%0d]", e.respIdx), mstRdata[e.respIdx], tgtRdata[t]);
      end
    end
  endtask

  initial begin
    int totalReps;
    totalReps = 0;
    seed = 32'hfaf2bada;
    rstN = 1'b0;
    mstReq = '0;
    mstAddr = '0;
    mstWdata = '0;
    mstRdy = '0;
    tgtGnt = '0;
    tgtVld = '0;
    tgtRespIdx = '0;
    tgtRdata = '0;
    conflictMask = '0;
    reqPending = '0;
    rspPending = '0;
    for (int p = 0; p < bflyPkg::NumPorts; p++) begin
      winCount[p] = 0;
    end
    for (int e = 0; e < NumEntries; e++) begin
      totalReps += stimTable[e].reps;
    end
    timeoutLimit = totalReps + ResetCycles + TimeoutMargin;

    repeat (ResetCycles) @(posedge clk);
    #DriveDelay;
    rstN = 1'b1;

    for (int e = 0; e < NumEntries; e++) begin
      for (int r = 0; r < stimTable[e].reps; r++) begin
        applyEntry(stimTable[e]);
        // sample just before the next rising edge
        #(ClkPeriod - DriveDelay - 1);
        checkEntry(stimTable[e]);
        reqPending = mstReq & ~mstGnt;
        rspPending = tgtVld & ~tgtRdy;
        @(posedge clk);
        #DriveDelay;
      end
    end

    for (int m = 0; m < bflyPkg::NumPorts; m++) begin
      if (conflictMask[m]) begin
        checkTrue(winCount[m] > 0, $sformatf("master %0d never won a conflict", m));
      end
    end

    $display("checks: %0d, errors: %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bflyNet.f
+incdir+test
logic/bflyPkg.sv
logic/bflySwitch.sv
logic/bflyStage.sv
logic/bflyPrioLfsr.sv
logic/bflyNet.sv
test/bflyNetTb.sv
